// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       := tcp_conn_tb
FILELIST  := filelist.f
PASS_STR  := ALL CHECKS PASSED

OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := $(wildcard verif/*.svh)

.PHONY: all run clean

all: run

# rebuilt only when a source, header or the file list changes
$(BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the pass line decides the status, not the simulator exit code
run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_STR)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/tcp_conn_top.sv
`timescale 1ns/1ns

module tcp_conn_top #(
    parameter tcp_pkg::seq_num_t INIT_SEQ         = 32'h0000_1000,
    parameter int                TIME_WAIT_CYCLES = 64
) (
    input  logic                i_clk,
    input  logic                i_rst,

    input  logic                i_enable,
    input  logic                i_open,
    output logic                o_open_clr,
    input  logic                i_close,
    output logic                o_close_clr,

    input  tcp_pkg::tcp_hdr_t   i_rx_hdr,
    input  logic                i_rx_hdr_valid,

    output tcp_pkg::tcp_hdr_t   o_tx_hdr,
    output logic                o_tx_hdr_valid,
    input  logic                i_tx_hdr_ack,

    output tcp_pkg::tcp_state_t o_state
);

    tcp_pkg::tx_ctrl_t tx_ctrl;
    logic              tx_ctrl_valid;
    logic              tx_ctrl_ack;

    tcp_pkg::rx_msg_t  rx_msg;
    logic              rx_msg_valid;
    logic              rx_msg_ack;

    tcp_pkg::seq_num_t rcv_nxt;    // next peer sequence number, used for outgoing acks.

    tcp_state_manager #(
        .TIME_WAIT_CYCLES (TIME_WAIT_CYCLES)
    ) u_state_manager (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_enable        (i_enable),
        .i_open          (i_open),
        .o_open_clr      (o_open_clr),
        .i_close         (i_close),
        .o_close_clr     (o_close_clr),
        .o_tx_ctrl       (tx_ctrl),
        .o_tx_ctrl_valid (tx_ctrl_valid),
        .i_tx_ctrl_ack   (tx_ctrl_ack),
        .i_rx_msg        (rx_msg),
        .i_rx_msg_valid  (rx_msg_valid),
        .o_rx_msg_ack    (rx_msg_ack),
        .o_state         (o_state)
    );

    tcp_rx_parser u_rx_parser (
        .i_clk          (i_clk),
        .i_rst          (i_rst),
        .i_enable       (i_enable),
        .i_rx_hdr       (i_rx_hdr),
        .i_rx_hdr_valid (i_rx_hdr_valid),
        .o_rx_msg       (rx_msg),
        .o_rx_msg_valid (rx_msg_valid),
        .i_rx_msg_ack   (rx_msg_ack),
        .o_rcv_nxt      (rcv_nxt)
    );

    tcp_tx_builder #(
        .INIT_SEQ (INIT_SEQ)
    ) u_tx_builder (
        .i_clk           (i_clk),
        .i_rst           (i_rst),
        .i_enable        (i_enable),
        .i_tx_ctrl       (tx_ctrl),
        .i_tx_ctrl_valid (tx_ctrl_valid),
        .o_tx_ctrl_ack   (tx_ctrl_ack),
        .i_rcv_nxt       (rcv_nxt),
        .o_tx_hdr        (o_tx_hdr),
        .o_tx_hdr_valid  (o_tx_hdr_valid),
        .i_tx_hdr_ack    (i_tx_hdr_ack)
    );

endmodule

// File: design/tcp_pkg.sv
package tcp_pkg;

    // sequence and acknowledgment numbers share one width.
    typedef logic [31:0] seq_num_t;

    // flag byte as carried in the header, cwr down to fin.
    typedef logic [7:0] tcp_flags_t;

    // bit positions inside tcp_flags_t.
    localparam int FLAG_FIN = 0;
    localparam int FLAG_SYN = 1;
    localparam int FLAG_RST = 2;
    localparam int FLAG_ACK = 4;

    // control requests from the state manager to the tx builder.
    typedef enum logic [1:0] {
        TX_CTRL_NOP,
        TX_CTRL_SEND_SYN,
        TX_CTRL_SEND_ACK,
        TX_CTRL_SEND_FIN
    } tx_ctrl_t;

    // received segment kinds, rx parser to state manager.
    typedef enum logic [2:0] {
        RX_MSG_NONE,
        RX_MSG_RECV_SYNACK,
        RX_MSG_RECV_ACK,
        RX_MSG_RECV_FIN,
        RX_MSG_RECV_FINACK,
        RX_MSG_RECV_RST,
        RX_MSG_OTHER
    } rx_msg_t;

    // the part of the tcp header this path cares about, 72 bits.
    typedef struct packed {
        seq_num_t   seq;
        seq_num_t   ack;
        tcp_flags_t flags;
    } tcp_hdr_t;

    // connection states, active open only.
    typedef enum logic [3:0] {
        IDLE,
        SYN_SENT_1,
        SYN_SENT_2,
        ESTABLISHED,
        LAST_ACK,
        FIN_WAIT_1,
        FIN_WAIT_2,
        TIME_WAIT
    } tcp_state_t;

endpackage

// File: design/tcp_rx_parser.sv
`timescale 1ns/1ns

module tcp_rx_parser (
    input  logic              i_clk,
    input  logic              i_rst,

    input  logic              i_enable,

    input  tcp_pkg::tcp_hdr_t i_rx_hdr,
    input  logic              i_rx_hdr_valid,

    output tcp_pkg::rx_msg_t  o_rx_msg,
    output logic              o_rx_msg_valid,
    input  logic              i_rx_msg_ack,

    output tcp_pkg::seq_num_t o_rcv_nxt
);

    tcp_pkg::rx_msg_t  msg_d;
    tcp_pkg::rx_msg_t  msg_q;
    logic              valid_q;
    tcp_pkg::seq_num_t rcv_nxt_q;
    logic              uses_seq;   // syn and fin each take one sequence number.

    // rst first, then the handshake and close combinations.
    function automatic tcp_pkg::rx_msg_t classify(input tcp_pkg::tcp_flags_t flags);
        logic syn;
        logic ack;
        logic fin;
        syn = flags[tcp_pkg::FLAG_SYN];
        ack = flags[tcp_pkg::FLAG_ACK];
        fin = flags[tcp_pkg::FLAG_FIN];
        if (flags[tcp_pkg::FLAG_RST]) begin
            return tcp_pkg::RX_MSG_RECV_RST;
        end else if (syn && ack && !fin) begin
            return tcp_pkg::RX_MSG_RECV_SYNACK;
        end else if (fin && ack && !syn) begin
            return tcp_pkg::RX_MSG_RECV_FINACK;
        end else if (fin && !ack && !syn) begin
            return tcp_pkg::RX_MSG_RECV_FIN;
        end else if (ack && !syn && !fin) begin
            return tcp_pkg::RX_MSG_RECV_ACK;
        end
        return tcp_pkg::RX_MSG_OTHER;
    endfunction

    assign msg_d    = classify(i_rx_hdr.flags);
    assign uses_seq = i_rx_hdr.flags[tcp_pkg::FLAG_SYN] || i_rx_hdr.flags[tcp_pkg::FLAG_FIN];

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q   <= 1'b0;
            msg_q     <= tcp_pkg::RX_MSG_NONE;
            rcv_nxt_q <= '0;
        end else if (!i_enable) begin
            valid_q   <= 1'b0;
            msg_q     <= tcp_pkg::RX_MSG_NONE;
            rcv_nxt_q <= '0;
        end else begin
            if (i_rx_hdr_valid) begin
                valid_q <= 1'b1;    // a new segment overwrites a held one.
                msg_q   <= msg_d;
            end else if (i_rx_msg_ack) begin
                valid_q <= 1'b0;
                msg_q   <= tcp_pkg::RX_MSG_NONE;
            end

            if (i_rx_hdr_valid && uses_seq) begin
                rcv_nxt_q <= i_rx_hdr.seq + 32'd1;
            end
        end
    end

    assign o_rx_msg       = msg_q;
    assign o_rx_msg_valid = valid_q;
    assign o_rcv_nxt      = rcv_nxt_q;

endmodule

// File: design/tcp_state_manager.sv
`timescale 1ns/1ns

module tcp_state_manager #(
    parameter int TIME_WAIT_CYCLES = 64
) (
    input  logic                i_clk,
    input  logic                i_rst,

    input  logic                i_enable,

    input  logic                i_open,
    output logic                o_open_clr,
    input  logic                i_close,
    output logic                o_close_clr,

    output tcp_pkg::tx_ctrl_t   o_tx_ctrl,
    output logic                o_tx_ctrl_valid,
    input  logic                i_tx_ctrl_ack,

    input  tcp_pkg::rx_msg_t    i_rx_msg,
    input  logic                i_rx_msg_valid,
    output logic                o_rx_msg_ack,

    output tcp_pkg::tcp_state_t o_state
);

    localparam int CNT_W = (TIME_WAIT_CYCLES > 1) ? $clog2(TIME_WAIT_CYCLES) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TIME_WAIT_CYCLES - 1);

    tcp_pkg::tcp_state_t state_q;
    tcp_pkg::tcp_state_t state_d;
    logic [CNT_W-1:0]    tw_cnt_q;   // cycles spent in time_wait.

    logic msg_synack;
    logic msg_ack;
    logic msg_fin;
    logic msg_finack;
    logic msg_rst;

    assign msg_synack = i_rx_msg_valid && (i_rx_msg == tcp_pkg::RX_MSG_RECV_SYNACK);
    assign msg_ack    = i_rx_msg_valid && (i_rx_msg == tcp_pkg::RX_MSG_RECV_ACK);
    assign msg_fin    = i_rx_msg_valid && (i_rx_msg == tcp_pkg::RX_MSG_RECV_FIN);
    assign msg_finack = i_rx_msg_valid && (i_rx_msg == tcp_pkg::RX_MSG_RECV_FINACK);
    assign msg_rst    = i_rx_msg_valid && (i_rx_msg == tcp_pkg::RX_MSG_RECV_RST);

    assign o_state = state_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state_q <= tcp_pkg::IDLE;
        end else if (!i_enable) begin
            state_q <= tcp_pkg::IDLE;   // disable drops the connection.
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            tw_cnt_q <= '0;
        end else if (state_q != tcp_pkg::TIME_WAIT) begin
            tw_cnt_q <= '0;
        end else begin
            tw_cnt_q <= tw_cnt_q + 1'b1;
        end
    end

    always_comb begin
        state_d         = state_q;
        o_tx_ctrl       = tcp_pkg::TX_CTRL_NOP;
        o_tx_ctrl_valid = 1'b0;
        o_open_clr      = 1'b0;
        o_close_clr     = 1'b0;
        o_rx_msg_ack    = i_rx_msg_valid;  // messages not used here are dropped.

        case (state_q)
            tcp_pkg::IDLE: begin
                if (i_open) begin
                    o_tx_ctrl       = tcp_pkg::TX_CTRL_SEND_SYN;
                    o_tx_ctrl_valid = 1'b1;
                    if (i_tx_ctrl_ack) begin
                        o_open_clr = 1'b1;
                        state_d    = tcp_pkg::SYN_SENT_1;
                    end
                end
            end

            tcp_pkg::SYN_SENT_1: begin
                if (msg_synack) begin
                    state_d = tcp_pkg::SYN_SENT_2;
                end
            end

            tcp_pkg::SYN_SENT_2: begin
                o_tx_ctrl       = tcp_pkg::TX_CTRL_SEND_ACK;
                o_tx_ctrl_valid = 1'b1;
                if (i_tx_ctrl_ack) begin
                    state_d = tcp_pkg::ESTABLISHED;
                end
            end

            tcp_pkg::ESTABLISHED: begin
                if (msg_fin) begin
                    // peer closes first, answer with fin+ack right away.
                    o_tx_ctrl       = tcp_pkg::TX_CTRL_SEND_FIN;
                    o_tx_ctrl_valid = 1'b1;
                    o_rx_msg_ack    = i_tx_ctrl_ack;  // keep the fin until the builder takes it.
                    if (i_tx_ctrl_ack) begin
                        state_d = tcp_pkg::LAST_ACK;
                    end
                end else if (i_close) begin
                    o_tx_ctrl       = tcp_pkg::TX_CTRL_SEND_FIN;
                    o_tx_ctrl_valid = 1'b1;
                    if (i_tx_ctrl_ack) begin
                        o_close_clr = 1'b1;
                        state_d     = tcp_pkg::FIN_WAIT_1;
                    end
                end
            end

            tcp_pkg::LAST_ACK: begin
                if (msg_ack) begin
                    state_d = tcp_pkg::IDLE;
                end
            end

            tcp_pkg::FIN_WAIT_1: begin
                if (msg_ack) begin
                    state_d = tcp_pkg::FIN_WAIT_2;
                end else if (msg_finack) begin
                    o_tx_ctrl       = tcp_pkg::TX_CTRL_SEND_ACK;
                    o_tx_ctrl_valid = 1'b1;
                    o_rx_msg_ack    = i_tx_ctrl_ack;
                    if (i_tx_ctrl_ack) begin
                        state_d = tcp_pkg::TIME_WAIT;
                    end
                end
            end

            tcp_pkg::FIN_WAIT_2: begin
                if (msg_fin) begin
                    o_tx_ctrl       = tcp_pkg::TX_CTRL_SEND_ACK;
                    o_tx_ctrl_valid = 1'b1;
                    o_rx_msg_ack    = i_tx_ctrl_ack;
                    if (i_tx_ctrl_ack) begin
                        state_d = tcp_pkg::TIME_WAIT;
                    end
                end
            end

            tcp_pkg::TIME_WAIT: begin
                if (tw_cnt_q == CNT_LAST) begin
                    state_d = tcp_pkg::IDLE;
                end
            end

            default: begin
                state_d = tcp_pkg::IDLE;
            end
        endcase

        // a reset segment wins over any pending request.
        if (msg_rst && (state_q != tcp_pkg::IDLE)) begin
            state_d         = tcp_pkg::IDLE;
            o_tx_ctrl       = tcp_pkg::TX_CTRL_NOP;
            o_tx_ctrl_valid = 1'b0;
            o_close_clr     = 1'b0;
        end
    end

endmodule

// File: design/tcp_tx_builder.sv
`timescale 1ns/1ns

module tcp_tx_builder #(
    parameter tcp_pkg::seq_num_t INIT_SEQ = 32'h0000_1000
) (
    input  logic              i_clk,
    input  logic              i_rst,

    input  logic              i_enable,

    input  tcp_pkg::tx_ctrl_t i_tx_ctrl,
    input  logic              i_tx_ctrl_valid,
    output logic              o_tx_ctrl_ack,

    input  tcp_pkg::seq_num_t i_rcv_nxt,

    output tcp_pkg::tcp_hdr_t o_tx_hdr,
    output logic              o_tx_hdr_valid,
    input  logic              i_tx_hdr_ack
);

    tcp_pkg::seq_num_t snd_nxt_q;
    tcp_pkg::tcp_hdr_t hdr_d;
    tcp_pkg::tcp_hdr_t hdr_q;
    logic              valid_q;
    logic              take;      // request accepted this cycle.
    logic              emit;      // request produces a segment.
    logic              advance;

    // only take a request when nothing is waiting on the output.
    assign take          = i_enable && i_tx_ctrl_valid && !valid_q;
    assign o_tx_ctrl_ack = take;

    always_comb begin
        hdr_d     = '0;
        hdr_d.seq = snd_nxt_q;
        emit      = 1'b1;

        case (i_tx_ctrl)
            tcp_pkg::TX_CTRL_SEND_SYN: begin
                hdr_d.flags[tcp_pkg::FLAG_SYN] = 1'b1;
            end
            tcp_pkg::TX_CTRL_SEND_ACK: begin
                hdr_d.flags[tcp_pkg::FLAG_ACK] = 1'b1;
            end
            tcp_pkg::TX_CTRL_SEND_FIN: begin
                hdr_d.flags[tcp_pkg::FLAG_FIN] = 1'b1;  // fin always goes out with ack.
                hdr_d.flags[tcp_pkg::FLAG_ACK] = 1'b1;
            end
            default: begin
                emit = 1'b0;
            end
        endcase

        if (hdr_d.flags[tcp_pkg::FLAG_ACK]) begin
            hdr_d.ack = i_rcv_nxt;
        end

        advance = hdr_d.flags[tcp_pkg::FLAG_SYN] || hdr_d.flags[tcp_pkg::FLAG_FIN];
    end

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            valid_q   <= 1'b0;
            snd_nxt_q <= INIT_SEQ;
        end else if (!i_enable) begin
            valid_q   <= 1'b0;
            snd_nxt_q <= INIT_SEQ;  // a new connection starts over.
        end else begin
            if (take && emit) begin
                valid_q <= 1'b1;
                if (advance) begin
                    snd_nxt_q <= snd_nxt_q + 32'd1;
                end
            end else if (i_tx_hdr_ack) begin
                valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (take) begin
            hdr_q <= hdr_d;
        end
    end

    assign o_tx_hdr       = hdr_q;
    assign o_tx_hdr_valid = valid_q;

endmodule

// File: filelist.f
+incdir+verif
design/tcp_pkg.sv
design/tcp_state_manager.sv
design/tcp_rx_parser.sv
design/tcp_tx_builder.sv
design/tcp_conn_top.sv
verif/tcp_conn_tb.sv

// File: verif/tcp_conn_tb_ref.svh
`ifndef TCP_CONN_TB_REF_SVH
`define TCP_CONN_TB_REF_SVH

    // single bits of the flag byte.
    localparam tcp_pkg::tcp_flags_t F_FIN = tcp_pkg::tcp_flags_t'(1 << tcp_pkg::FLAG_FIN);
    localparam tcp_pkg::tcp_flags_t F_SYN = tcp_pkg::tcp_flags_t'(1 << tcp_pkg::FLAG_SYN);
    localparam tcp_pkg::tcp_flags_t F_RST = tcp_pkg::tcp_flags_t'(1 << tcp_pkg::FLAG_RST);
    localparam tcp_pkg::tcp_flags_t F_ACK = tcp_pkg::tcp_flags_t'(1 << tcp_pkg::FLAG_ACK);

    // header the builder owes for a request, from our own copies of both sequences.
    function automatic tcp_pkg::tcp_hdr_t expect_hdr(
        input tcp_pkg::tx_ctrl_t kind,
        input tcp_pkg::seq_num_t snd,
        input tcp_pkg::seq_num_t rcv
    );
        tcp_pkg::tcp_hdr_t hdr;
        hdr     = '0;
        hdr.seq = snd;
        case (kind)
            tcp_pkg::TX_CTRL_SEND_SYN: hdr.flags = F_SYN;
            tcp_pkg::TX_CTRL_SEND_ACK: hdr.flags = F_ACK;
            tcp_pkg::TX_CTRL_SEND_FIN: hdr.flags = F_FIN | F_ACK;  // fin never goes alone.
            default:                   hdr.flags = '0;
        endcase
        if ((hdr.flags & F_ACK) != '0) begin
            hdr.ack = rcv;
        end
        return hdr;
    endfunction

    task automatic check_hdr(input tcp_pkg::tcp_hdr_t got, input tcp_pkg::tcp_hdr_t exp,
                             input string what);
        if (got !== exp) begin
            fail_now($sformatf("ERROR at %0t: %s seq/ack/flags %h/%h/%h, expected %h/%h/%h",
                               $time, what, got.seq, got.ack, got.flags,
                               exp.seq, exp.ack, exp.flags));
        end
    endtask

    task automatic check_state(input tcp_pkg::tcp_state_t got, input tcp_pkg::tcp_state_t exp,
                               input string what);
        if (got !== exp) begin
            fail_now($sformatf("ERROR at %0t: %s is %s, expected %s",
                               $time, what, got.name(), exp.name()));
        end
    endtask

    task automatic check_pulse(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_now($sformatf("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

`endif

// File: verif/tcp_conn_tb.sv
`timescale 1ns/1ns

module tcp_conn_tb;

    localparam tcp_pkg::seq_num_t INIT_SEQ = 32'h5a3c_0100;
    localparam int TW_CYCLES  = 6;
    localparam int NUM_SEQ    = 6;
    localparam int SEQ_CYCLES = 200;

    logic                i_clk;
    logic                i_rst;
    logic                i_enable;
    logic                i_open;
    logic                i_close;
    tcp_pkg::tcp_hdr_t   i_rx_hdr;
    logic                i_rx_hdr_valid;
    logic                i_tx_hdr_ack;
    logic                o_open_clr;
    logic                o_close_clr;
    tcp_pkg::tcp_hdr_t   o_tx_hdr;
    logic                o_tx_hdr_valid;
    tcp_pkg::tcp_state_t o_state;

    integer              seed = 76917;
    tcp_pkg::seq_num_t   snd_nxt;    // local send sequence, as the peer sees it.
    tcp_pkg::seq_num_t   rcv_nxt;
    tcp_pkg::tcp_hdr_t   exp_q[$];   // headers the DUT still owes.
    logic                prev_valid;
    logic                prev_ack;
    logic                prev_en;
    tcp_pkg::tcp_hdr_t   prev_hdr;

    `include "tcp_conn_tb_ref.svh"

    tcp_conn_top #(.INIT_SEQ(INIT_SEQ), .TIME_WAIT_CYCLES(TW_CYCLES)) DUT (.*);

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic step();
        @(posedge i_clk);
        #1;
    endtask

    task automatic expect_push(input tcp_pkg::tx_ctrl_t kind);
        exp_q.push_back(expect_hdr(kind, snd_nxt, rcv_nxt));
        if (kind == tcp_pkg::TX_CTRL_SEND_SYN || kind == tcp_pkg::TX_CTRL_SEND_FIN) begin
            snd_nxt = snd_nxt + 32'd1;
        end
    endtask

    // one-cycle segment strobe from the peer.
    task automatic send_seg(input tcp_pkg::tcp_flags_t flags, input tcp_pkg::seq_num_t seq);
        i_rx_hdr.seq   = seq;
        i_rx_hdr.ack   = snd_nxt;
        i_rx_hdr.flags = flags;
        i_rx_hdr_valid = 1'b1;
        if ((flags & (F_SYN | F_FIN)) != '0) begin
            rcv_nxt = seq + 32'd1;
        end
        step();
        i_rx_hdr_valid = 1'b0;
    endtask

    task automatic ack_hdr(input int forced);
        int stall;
        while (!o_tx_hdr_valid) begin
            step();
        end
        stall = (forced < 0) ? ($random(seed) & 3) : forced;  // 0 to 3 cycles.
        repeat (stall) step();
        i_tx_hdr_ack = 1'b1;
        step();
        i_tx_hdr_ack = 1'b0;
    endtask

    task automatic wait_clr_pulse(input bit is_close);
        int n;
        n = 0;
        @(negedge i_clk);
        while (!(is_close ? o_close_clr : o_open_clr) && n < 16) begin
            @(negedge i_clk);
            n++;
        end
        check_pulse(is_close ? o_close_clr : o_open_clr, 1'b1, "clr pulse");
        step();
        i_open  = 1'b0;
        i_close = 1'b0;
        @(negedge i_clk);
        check_pulse(is_close ? o_close_clr : o_open_clr, 1'b0, "clr after pulse");
        step();
    endtask

    task automatic wait_state(input tcp_pkg::tcp_state_t exp, input int limit);
        int n;
        n = 0;
        while (o_state != exp && n < limit) begin
            step();
            n++;
        end
        check_state(o_state, exp, "state");
    endtask

    task automatic active_open(input int forced);
        tcp_pkg::seq_num_t peer_seq;
        peer_seq = $random(seed);
        expect_push(tcp_pkg::TX_CTRL_SEND_SYN);
        i_open = 1'b1;
        wait_clr_pulse(1'b0);
        ack_hdr(forced);
        check_state(o_state, tcp_pkg::SYN_SENT_1, "state after syn");
        send_seg(F_SYN | F_ACK, peer_seq);
        expect_push(tcp_pkg::TX_CTRL_SEND_ACK);
        ack_hdr(forced);
        check_state(o_state, tcp_pkg::ESTABLISHED, "state after handshake");
    endtask

    task automatic passive_close();
        send_seg(F_FIN, rcv_nxt);
        expect_push(tcp_pkg::TX_CTRL_SEND_FIN);
        ack_hdr(-1);
        check_state(o_state, tcp_pkg::LAST_ACK, "state after peer fin");
        send_seg(F_ACK, rcv_nxt);
        wait_state(tcp_pkg::IDLE, 8);
    endtask

    task automatic active_close(input bit combined, input int forced);
        expect_push(tcp_pkg::TX_CTRL_SEND_FIN);
        i_close = 1'b1;
        wait_clr_pulse(1'b1);
        ack_hdr(forced);
        check_state(o_state, tcp_pkg::FIN_WAIT_1, "state after local fin");
        if (combined) begin
            send_seg(F_FIN | F_ACK, rcv_nxt);
        end else begin
            send_seg(F_ACK, rcv_nxt);
            wait_state(tcp_pkg::FIN_WAIT_2, 8);
            send_seg(F_FIN, rcv_nxt);
        end
        expect_push(tcp_pkg::TX_CTRL_SEND_ACK);
        ack_hdr(forced);
        check_state(o_state, tcp_pkg::TIME_WAIT, "state after last ack");
        wait_state(tcp_pkg::IDLE, TW_CYCLES + 4);
    endtask

    // held headers stay put, every transfer matches the next expected header.
    always @(negedge i_clk) begin
        if (i_rst) begin
            prev_valid = 1'b0;
        end else begin
            if (prev_valid && !prev_ack && prev_en && i_enable) begin
                check_pulse(o_tx_hdr_valid, 1'b1, "held header valid");
                check_hdr(o_tx_hdr, prev_hdr, "held header");
            end
            if (o_tx_hdr_valid && i_tx_hdr_ack) begin
                if (exp_q.size() == 0) begin
                    fail_now("the DUT sent a header that no request explains");
                end else begin
                    check_hdr(o_tx_hdr, exp_q.pop_front(), "outgoing header");
                end
            end
            prev_valid = o_tx_hdr_valid;
            prev_ack   = i_tx_hdr_ack;
            prev_en    = i_enable;
            prev_hdr   = o_tx_hdr;
        end
    end

    initial begin
        repeat (NUM_SEQ * SEQ_CYCLES) @(posedge i_clk);
        fail_now("watchdog expired, the DUT stopped making progress");
    end

    initial begin
        i_rst          = 1'b1;
        i_enable       = 1'b1;
        i_open         = 1'b0;
        i_close        = 1'b0;
        i_rx_hdr       = '0;
        i_rx_hdr_valid = 1'b0;
        i_tx_hdr_ack   = 1'b0;
        snd_nxt        = INIT_SEQ;
        rcv_nxt        = '0;
        repeat (3) @(posedge i_clk);
        #1;
        i_rst = 1'b0;
        check_state(o_state, tcp_pkg::IDLE, "state after reset");
        check_pulse(o_tx_hdr_valid, 1'b0, "tx valid after reset");

        active_open(-1);
        passive_close();
        active_open(-1);
        active_close(1'b0, -1);
        active_open(-1);
        active_close(1'b1, -1);

        // rst segment in established, nothing goes out.
        active_open(-1);
        send_seg(F_RST, rcv_nxt);
        wait_state(tcp_pkg::IDLE, 8);
        repeat (4) step();
        check_pulse(o_tx_hdr_valid, 1'b0, "tx valid after rst");

        // drop enable while the syn is still held.
        i_open = 1'b1;
        wait_clr_pulse(1'b0);
        check_pulse(o_tx_hdr_valid, 1'b1, "syn held");
        i_enable = 1'b0;
        step();
        i_enable = 1'b1;
        check_state(o_state, tcp_pkg::IDLE, "state after disable");
        check_pulse(o_tx_hdr_valid, 1'b0, "tx valid after disable");
        snd_nxt = INIT_SEQ;
        rcv_nxt = '0;

        active_open(3);    // longest stall on every header.
        active_close(1'b1, 3);

        repeat (4) step();
        if (exp_q.size() != 0) begin
            fail_now("some expected headers were never sent");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule
